// File: vlog.f
rtl/ray_core_pkg.sv
rtl/ray_fifo.sv
rtl/surface_stage.sv
rtl/shadow_stage.sv
rtl/shade_stage.sv
rtl/ray_core.sv
verif/ray_core_tb.sv

// File: Makefile
# Verilator build and run for the ray core testbench

VERILATOR ?= verilator
TOP       ?= ray_core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTBENCH PASSED

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/ray_core_tb.sv
// Directed testbench for the ray core that scores each pixel against a model of the shade rules
`timescale 1ns/10ps
`default_nettype none

module ray_core_tb;

    import ray_core_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int MAX_BOUNCES = 2;
    // Total rays over all tests for the watchdog
    localparam int TOTAL_RAYS  = 54;

    logic                      clk;
    logic                      resetn;
    logic                      add_input;
    logic [COORD_W-1:0]        px;
    logic [COORD_W-1:0]        py;
    logic signed [DIR_W-1:0]   dir_y;
    logic [COLOR_W-1:0]        plane_color;
    logic [COLOR_W-1:0]        sky_color;
    logic [COORD_W-1:0]        shadow_x_lo;
    logic [COORD_W-1:0]        shadow_x_hi;
    logic                      reflective;
    logic                      clear_pixel_count;
    logic                      fifo_full;
    logic                      valid;
    logic [PIX_W-1:0]          pixel_index;
    logic [COLOR_W-1:0]        color;
    logic [31:0]               pixel_counter;

    // Expected colour of each pixel still in flight
    logic [COLOR_W-1:0]        exp_color [logic [PIX_W-1:0]];
    logic [15:0]               lfsr_state;
    int                        rays_sent;
    int                        next_row;
    int                        checks_done;
    int                        check_errors;
    int                        other_errors;

    ray_core #(.FIFO_DEPTH(FIFO_DEPTH), .MAX_BOUNCES(MAX_BOUNCES)) u_ray_core (
        .clk(clk), .resetn(resetn), .add_input(add_input),
        .px(px), .py(py), .dir_y(dir_y),
        .plane_color(plane_color), .sky_color(sky_color),
        .shadow_x_lo(shadow_x_lo), .shadow_x_hi(shadow_x_hi),
        .reflective(reflective), .clear_pixel_count(clear_pixel_count),
        .fifo_full(fifo_full), .valid(valid), .pixel_index(pixel_index),
        .color(color), .pixel_counter(pixel_counter)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog allows 200 cycles per ray plus margin
    initial begin
        #((TOTAL_RAYS * 200 + 1000) * CLK_PERIOD);
        $display("Watchdog expired at %0t, the tests did not complete", $time);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    task automatic check_value(input string what, input int got, input int expected);
        checks_done++;
        if (got !== expected) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, expected);
            check_errors++;
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [7:0] draw_bits(input int n);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return value;
    endfunction

    // Walks the ray through floor, shadow and bounces with the current scene
    function automatic logic [COLOR_W-1:0] expected_color(input logic [COORD_W-1:0] x,
                                                          input logic signed [DIR_W-1:0] d);
        int                      total;
        int                      base;
        int                      b;
        logic signed [DIR_W-1:0] dd;
        logic                    is_hit;
        logic                    done;
        total = 0;
        b     = 0;
        dd    = d;
        done  = 1'b0;
        while (!done) begin
            is_hit = (dd < 0);
            if (!is_hit)
                base = sky_color;
            else if (x >= shadow_x_lo && x < shadow_x_hi)
                base = plane_color / 2;
            else
                base = plane_color;
            total = total + (base >> b);
            if (total > COLOR_MAX) begin
                total = COLOR_MAX;
            end
            if (is_hit && reflective && b < MAX_BOUNCES) begin
                dd = -dd;
                b++;
            end else begin
                done = 1'b1;
            end
        end
        return total[COLOR_W-1:0];
    endfunction

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic send_ray(input logic [COORD_W-1:0] x, input logic signed [DIR_W-1:0] d);
        while (fifo_full) begin
            @(posedge clk);
            #1;
        end
        add_input = 1'b1;
        px        = x;
        py        = next_row[COORD_W-1:0];
        dir_y     = d;
        exp_color[{py, x}] = expected_color(x, d);
        next_row++;
        rays_sent++;
        @(posedge clk);
        #1;
        add_input = 1'b0;
    endtask

    task automatic begin_test(input string name);
        $display("Test %s at %0t", name, $time);
        rays_sent         = 0;
        next_row          = 0;
        clear_pixel_count = 1'b1;
        @(posedge clk);
        #1;
        clear_pixel_count = 1'b0;
        check_value("pixel_counter after clear", pixel_counter, 0);
    endtask

    // Waits for every sent pixel within a bound set by the ray count
    task automatic finish_test();
        int cycles;
        cycles = 0;
        while (exp_color.num() > 0 && cycles < 200 * rays_sent) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (exp_color.num() > 0) begin
            $display("%0d pixels never arrived by %0t", exp_color.num(), $time);
            foreach (exp_color[idx]) begin
                $display("  missing pixel index %h", idx);
            end
            other_errors++;
            exp_color.delete();
        end
        // Idle time for late duplicates and the counter update
        repeat (8) @(posedge clk);
        #1;
        check_value("pixel_counter after test", pixel_counter, rays_sent);
    endtask

    // Monitor pops one expected pixel per valid
    always @(negedge clk) begin
        if (resetn && valid) begin
            if (exp_color.exists(pixel_index)) begin
                check_value($sformatf("colour of pixel %h", pixel_index), color,
                            exp_color[pixel_index]);
                exp_color.delete(pixel_index);
            end else begin
                $display("Pixel %h arrived at %0t but was not sent or came twice",
                         pixel_index, $time);
                other_errors++;
            end
        end
    end

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------

    task automatic sky_and_floor();
        begin_test("sky and lit floor");
        plane_color = 8'd90;
        sky_color   = 8'd30;
        shadow_x_lo = 8'd100;
        shadow_x_hi = 8'd120;
        reflective  = 1'b0;
        send_ray(8'd10, 8'sd20);
        send_ray(8'd20, 8'sd0);
        send_ray(8'd30, -8'sd1);
        send_ray(8'd200, -8'sd90);
        finish_test();
    endtask

    // Odd plane colour so the halving rounds down
    task automatic shadow_edges();
        begin_test("shadow band edges");
        plane_color = 8'd201;
        shadow_x_lo = 8'd40;
        shadow_x_hi = 8'd80;
        reflective  = 1'b0;
        send_ray(8'd40, -8'sd20);
        send_ray(8'd79, -8'sd20);
        send_ray(8'd80, -8'sd20);
        send_ray(8'd39, -8'sd20);
        finish_test();
    endtask

    task automatic reflection();
        begin_test("reflection");
        shadow_x_lo = 8'd40;
        shadow_x_hi = 8'd80;
        reflective  = 1'b1;
        // No saturation first and then the lit floor clips at the maximum
        for (int s = 0; s < 2; s++) begin
            plane_color = (s == 0) ? 8'd100 : 8'd200;
            sky_color   = (s == 0) ? 8'd60 : 8'd180;
            send_ray(8'd10, -8'sd30);
            send_ray(8'd50, -8'sd30);
            send_ray(8'd12, 8'sd30);
            finish_test();
        end
    endtask

    // Two halves with the scene changed only once the first has drained
    task automatic backpressure_burst();
        logic [7:0] x;
        logic [7:0] d;
        begin_test("back-pressure burst");
        plane_color = 8'd150;
        sky_color   = 8'd120;
        shadow_x_lo = 8'd64;
        shadow_x_hi = 8'd160;
        for (int half = 0; half < 2; half++) begin
            reflective = (half == 1);
            for (int i = 0; i < 20; i++) begin
                x = draw_bits(8);
                d = draw_bits(8);
                send_ray(x, d);
            end
            finish_test();
        end
    endtask

    initial begin
        resetn            = 1'b0;
        add_input         = 1'b0;
        px                = '0;
        py                = '0;
        dir_y             = '0;
        plane_color       = '0;
        sky_color         = '0;
        shadow_x_lo       = '0;
        shadow_x_hi       = '0;
        reflective        = 1'b0;
        clear_pixel_count = 1'b0;
        lfsr_state        = 16'd25298;
        checks_done       = 0;
        check_errors      = 0;
        other_errors      = 0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(posedge clk);
        #1;
        check_value("valid after reset", valid, 0);
        check_value("fifo_full after reset", fifo_full, 0);
        check_value("pixel_counter after reset", pixel_counter, 0);

        sky_and_floor();
        shadow_edges();
        reflection();
        backpressure_burst();

        $display("Summary: %0d checks, %0d check errors, %0d other errors",
                 checks_done, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/ray_core.sv
// Top of the ray core: chains surface, shadow and shade stages with the reflection loop
`timescale 1ns/10ps
`default_nettype none

module ray_core #(
    parameter int FIFO_DEPTH  = 4,
    parameter int MAX_BOUNCES = 2
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  add_input,
    input  logic [ray_core_pkg::COORD_W-1:0]      px,
    input  logic [ray_core_pkg::COORD_W-1:0]      py,
    input  logic signed [ray_core_pkg::DIR_W-1:0] dir_y,
    // Scene, held static while rays run
    input  logic [ray_core_pkg::COLOR_W-1:0]      plane_color,
    input  logic [ray_core_pkg::COLOR_W-1:0]      sky_color,
    input  logic [ray_core_pkg::COORD_W-1:0]      shadow_x_lo,
    input  logic [ray_core_pkg::COORD_W-1:0]      shadow_x_hi,
    input  logic                                  reflective,
    input  logic                                  clear_pixel_count,
    output logic                                  fifo_full,
    output logic                                  valid,
    output logic [ray_core_pkg::PIX_W-1:0]        pixel_index,
    output logic [ray_core_pkg::COLOR_W-1:0]      color,
    output logic [31:0]                           pixel_counter
);

    import ray_core_pkg::*;

    // --------------------------------------------------
    // surface -> shadow -> shade, shade loops back
    // --------------------------------------------------

    // Surface to shadow
    logic                surf_valid;
    logic [COORD_W-1:0]  surf_px;
    logic [COORD_W-1:0]  surf_py;
    logic [DIR_W-1:0]    surf_dir_y;
    logic [BOUNCE_W-1:0] surf_bounce;
    logic [COLOR_W-1:0]  surf_acc;
    logic                surf_hit;
    logic                shdw_fifo_full;

    // Shadow to shade
    logic                shdw_valid;
    logic [COORD_W-1:0]  shdw_px;
    logic [COORD_W-1:0]  shdw_py;
    logic [DIR_W-1:0]    shdw_dir_y;
    logic [BOUNCE_W-1:0] shdw_bounce;
    logic [COLOR_W-1:0]  shdw_acc;
    logic                shdw_hit;
    logic                shdw_in_shadow;
    logic                shad_fifo_full;

    // Shade back to surface
    logic                ref_valid;
    logic [COORD_W-1:0]  ref_px;
    logic [COORD_W-1:0]  ref_py;
    logic [DIR_W-1:0]    ref_dir_y;
    logic [BOUNCE_W-1:0] ref_bounce;
    logic [COLOR_W-1:0]  ref_acc;
    logic                ref_fifo_full;

    // New rays start with no bounces and black
    surface_stage #(.DEPTH(FIFO_DEPTH), .MAX_BOUNCES(MAX_BOUNCES)) u_surface (
        .clk(clk), .resetn(resetn),
        .add_input(add_input), .px(px), .py(py), .dir_y(dir_y),
        .bounce('0), .acc('0),
        .add_ref_input(ref_valid), .ref_px(ref_px), .ref_py(ref_py),
        .ref_dir_y(ref_dir_y), .ref_bounce(ref_bounce), .ref_acc(ref_acc),
        .output_fifo_full(shdw_fifo_full),
        .fifo_full(fifo_full), .ref_fifo_full(ref_fifo_full), .valid(surf_valid),
        .out_px(surf_px), .out_py(surf_py), .out_dir_y(surf_dir_y),
        .out_bounce(surf_bounce), .out_acc(surf_acc), .hit(surf_hit)
    );

    shadow_stage #(.DEPTH(FIFO_DEPTH)) u_shadow (
        .clk(clk), .resetn(resetn),
        .add_input(surf_valid), .px(surf_px), .py(surf_py), .dir_y(surf_dir_y),
        .bounce(surf_bounce), .acc(surf_acc), .hit(surf_hit),
        .shadow_x_lo(shadow_x_lo), .shadow_x_hi(shadow_x_hi),
        .output_fifo_full(shad_fifo_full),
        .fifo_full(shdw_fifo_full), .valid(shdw_valid),
        .out_px(shdw_px), .out_py(shdw_py), .out_dir_y(shdw_dir_y),
        .out_bounce(shdw_bounce), .out_acc(shdw_acc),
        .out_hit(shdw_hit), .in_shadow(shdw_in_shadow)
    );

    shade_stage #(.DEPTH(FIFO_DEPTH), .MAX_BOUNCES(MAX_BOUNCES)) u_shade (
        .clk(clk), .resetn(resetn),
        .add_input(shdw_valid), .px(shdw_px), .py(shdw_py), .dir_y(shdw_dir_y),
        .bounce(shdw_bounce), .acc(shdw_acc), .hit(shdw_hit), .in_shadow(shdw_in_shadow),
        .plane_color(plane_color), .sky_color(sky_color), .reflective(reflective),
        .ref_fifo_full(ref_fifo_full), .clear_pixel_count(clear_pixel_count),
        .fifo_full(shad_fifo_full), .valid(valid),
        .pixel_index(pixel_index), .color(color),
        .ref_valid(ref_valid), .ref_px(ref_px), .ref_py(ref_py),
        .ref_dir_y(ref_dir_y), .ref_bounce(ref_bounce), .ref_acc(ref_acc),
        .pixel_counter(pixel_counter)
    );

endmodule

`default_nettype wire

// File: rtl/shade_stage.sv
// Output side of the ray loop that colours each ray, emits or reflects it and counts pixels
`timescale 1ns/10ps
`default_nettype none

module shade_stage #(
    parameter int DEPTH       = 4,
    parameter int MAX_BOUNCES = 2
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  add_input,
    input  logic [ray_core_pkg::COORD_W-1:0]      px,
    input  logic [ray_core_pkg::COORD_W-1:0]      py,
    input  logic signed [ray_core_pkg::DIR_W-1:0] dir_y,
    input  logic [ray_core_pkg::BOUNCE_W-1:0]     bounce,
    input  logic [ray_core_pkg::COLOR_W-1:0]      acc,
    input  logic                                  hit,
    input  logic                                  in_shadow,
    input  logic [ray_core_pkg::COLOR_W-1:0]      plane_color,
    input  logic [ray_core_pkg::COLOR_W-1:0]      sky_color,
    input  logic                                  reflective,
    input  logic                                  ref_fifo_full,
    input  logic                                  clear_pixel_count,
    output logic                                  fifo_full,
    output logic                                  valid,
    output logic [ray_core_pkg::PIX_W-1:0]        pixel_index,
    output logic [ray_core_pkg::COLOR_W-1:0]      color,
    output logic                                  ref_valid,
    output logic [ray_core_pkg::COORD_W-1:0]      ref_px,
    output logic [ray_core_pkg::COORD_W-1:0]      ref_py,
    output logic signed [ray_core_pkg::DIR_W-1:0] ref_dir_y,
    output logic [ray_core_pkg::BOUNCE_W-1:0]     ref_bounce,
    output logic [ray_core_pkg::COLOR_W-1:0]      ref_acc,
    output logic [31:0]                           pixel_counter
);

    import ray_core_pkg::*;

    // Ray word plus hit and in_shadow
    logic [RAY_W+1:0]    head;
    logic                empty;
    logic                pop;
    logic [COORD_W-1:0]  h_px;
    logic [COORD_W-1:0]  h_py;
    logic [DIR_W-1:0]    h_dir_y;
    logic [BOUNCE_W-1:0] h_bounce;
    logic [COLOR_W-1:0]  h_acc;
    logic                h_hit;
    logic                h_in_shadow;
    logic [COLOR_W-1:0]  base;
    logic [COLOR_W-1:0]  contrib;
    logic [COLOR_W:0]    sum;
    logic [COLOR_W-1:0]  new_acc;
    logic                do_ref;

    ray_fifo #(.DEPTH(DEPTH), .WIDTH(RAY_W + 2)) u_fifo (
        .clk(clk), .resetn(resetn),
        .push(add_input), .pop(pop),
        .din({px, py, dir_y, bounce, acc, hit, in_shadow}),
        .dout(head), .empty(empty), .full(fifo_full)
    );

    assign {h_px, h_py, h_dir_y, h_bounce, h_acc, h_hit, h_in_shadow} = head;

    // Pixel output is always accepted so only the loop can stall
    assign pop = !empty && !ref_fifo_full;

    // --------------------------------------------------
    // Colour
    // --------------------------------------------------

    always_comb begin
        if (!h_hit) begin
            base = sky_color;
        end else if (h_in_shadow) begin
            base = plane_color >> 1;
        end else begin
            base = plane_color;
        end
    end

    // Each bounce halves what it adds
    assign contrib = base >> h_bounce;
    assign sum     = {1'b0, h_acc} + {1'b0, contrib};
    assign new_acc = (sum > COLOR_MAX) ? COLOR_W'(COLOR_MAX) : sum[COLOR_W-1:0];

    // Reflect off a shiny floor while bounces remain
    assign do_ref  = h_hit && reflective && (h_bounce < MAX_BOUNCES);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid     <= 1'b0;
            ref_valid <= 1'b0;
        end else begin
            valid     <= pop && !do_ref;
            ref_valid <= pop && do_ref;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            pixel_index <= {h_py, h_px};
            color       <= new_acc;
            ref_dir_y   <= -h_dir_y;
            ref_bounce  <= h_bounce + 1'b1;
        end
    end

    // Reflected ray reuses the pixel and colour registers
    assign {ref_py, ref_px} = pixel_index;
    assign ref_acc          = color;

    // Clear wins over a pixel in the same cycle
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pixel_counter <= '0;
        end else if (clear_pixel_count) begin
            pixel_counter <= '0;
        end else if (valid) begin
            pixel_counter <= pixel_counter + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/shadow_stage.sv
// Middle stage of the ray loop: marks floor hits that fall inside the shadow band
`timescale 1ns/10ps
`default_nettype none

module shadow_stage #(
    parameter int DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  add_input,
    input  logic [ray_core_pkg::COORD_W-1:0]      px,
    input  logic [ray_core_pkg::COORD_W-1:0]      py,
    input  logic signed [ray_core_pkg::DIR_W-1:0] dir_y,
    input  logic [ray_core_pkg::BOUNCE_W-1:0]     bounce,
    input  logic [ray_core_pkg::COLOR_W-1:0]      acc,
    input  logic                                  hit,
    // Band covers columns lo up to but not including hi
    input  logic [ray_core_pkg::COORD_W-1:0]      shadow_x_lo,
    input  logic [ray_core_pkg::COORD_W-1:0]      shadow_x_hi,
    input  logic                                  output_fifo_full,
    output logic                                  fifo_full,
    output logic                                  valid,
    output logic [ray_core_pkg::COORD_W-1:0]      out_px,
    output logic [ray_core_pkg::COORD_W-1:0]      out_py,
    output logic signed [ray_core_pkg::DIR_W-1:0] out_dir_y,
    output logic [ray_core_pkg::BOUNCE_W-1:0]     out_bounce,
    output logic [ray_core_pkg::COLOR_W-1:0]      out_acc,
    output logic                                  out_hit,
    output logic                                  in_shadow
);

    import ray_core_pkg::*;

    // Ray word with hit appended at the bottom
    logic [RAY_W:0]       head;
    logic [COORD_W-1:0]   head_px;
    logic                 head_hit;
    logic                 empty;
    logic                 pop;

    ray_fifo #(.DEPTH(DEPTH), .WIDTH(RAY_W + 1)) u_fifo (
        .clk(clk), .resetn(resetn),
        .push(add_input), .pop(pop),
        .din({px, py, dir_y, bounce, acc, hit}),
        .dout(head), .empty(empty), .full(fifo_full)
    );

    assign pop      = !empty && !output_fifo_full;
    assign head_px  = head[RAY_W -: COORD_W];
    assign head_hit = head[0];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= pop;
        end
    end

    // Sky rays are never shadowed
    always_ff @(posedge clk) begin
        if (pop) begin
            {out_px, out_py, out_dir_y, out_bounce, out_acc, out_hit} <= head;
            in_shadow <= head_hit && (head_px >= shadow_x_lo) && (head_px < shadow_x_hi);
        end
    end

endmodule

`default_nettype wire

// File: rtl/surface_stage.sv
// Input side of the ray loop that merges new and reflected rays and tests each against the floor
`timescale 1ns/10ps
`default_nettype none

module surface_stage #(
    parameter int DEPTH       = 4,
    parameter int MAX_BOUNCES = 2
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    // New rays from outside
    input  logic                                  add_input,
    input  logic [ray_core_pkg::COORD_W-1:0]      px,
    input  logic [ray_core_pkg::COORD_W-1:0]      py,
    input  logic signed [ray_core_pkg::DIR_W-1:0] dir_y,
    input  logic [ray_core_pkg::BOUNCE_W-1:0]     bounce,
    input  logic [ray_core_pkg::COLOR_W-1:0]      acc,
    // Reflected rays from the shade stage
    input  logic                                  add_ref_input,
    input  logic [ray_core_pkg::COORD_W-1:0]      ref_px,
    input  logic [ray_core_pkg::COORD_W-1:0]      ref_py,
    input  logic signed [ray_core_pkg::DIR_W-1:0] ref_dir_y,
    input  logic [ray_core_pkg::BOUNCE_W-1:0]     ref_bounce,
    input  logic [ray_core_pkg::COLOR_W-1:0]      ref_acc,
    input  logic                                  output_fifo_full,
    output logic                                  fifo_full,
    output logic                                  ref_fifo_full,
    output logic                                  valid,
    output logic [ray_core_pkg::COORD_W-1:0]      out_px,
    output logic [ray_core_pkg::COORD_W-1:0]      out_py,
    output logic signed [ray_core_pkg::DIR_W-1:0] out_dir_y,
    output logic [ray_core_pkg::BOUNCE_W-1:0]     out_bounce,
    output logic [ray_core_pkg::COLOR_W-1:0]      out_acc,
    output logic                                  hit
);

    import ray_core_pkg::*;

    // Sign bit of dir_y inside the ray word
    localparam int DIR_MSB = BOUNCE_W + COLOR_W + DIR_W - 1;

    logic [RAY_W-1:0] new_head;
    logic [RAY_W-1:0] ref_head;
    logic [RAY_W-1:0] sel_ray;
    logic             new_empty;
    logic             ref_empty;
    logic             pop_new;
    logic             pop_ref;

    ray_fifo #(.DEPTH(DEPTH), .WIDTH(RAY_W)) u_new_fifo (
        .clk(clk), .resetn(resetn),
        .push(add_input), .pop(pop_new),
        .din({px, py, dir_y, bounce, acc}),
        .dout(new_head), .empty(new_empty), .full(fifo_full)
    );

    ray_fifo #(.DEPTH(DEPTH), .WIDTH(RAY_W)) u_ref_fifo (
        .clk(clk), .resetn(resetn),
        .push(add_ref_input), .pop(pop_ref),
        .din({ref_px, ref_py, ref_dir_y, ref_bounce, ref_acc}),
        .dout(ref_head), .empty(ref_empty), .full(ref_fifo_full)
    );

    // --------------------------------------------------
    // Arbitration with reflected rays first
    // --------------------------------------------------

    // Draining the loop before taking new work keeps it moving
    assign pop_ref = !ref_empty && !output_fifo_full;
    assign pop_new = !new_empty && ref_empty && !output_fifo_full;
    assign sel_ray = ref_empty ? new_head : ref_head;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= pop_ref || pop_new;
        end
    end

    // Fields pass through; the floor is hit by any downward ray
    always_ff @(posedge clk) begin
        if (pop_ref || pop_new) begin
            {out_px, out_py, out_dir_y, out_bounce, out_acc} <= sel_ray;
            hit <= sel_ray[DIR_MSB];
        end
    end

    assert property (@(posedge clk) disable iff (!resetn) add_input |-> !fifo_full)
        else $error("add_input while fifo_full");

    // Shade stage only reflects below the bounce limit
    assert property (@(posedge clk) disable iff (!resetn)
        add_ref_input |-> (ref_bounce != '0) && (ref_bounce <= MAX_BOUNCES))
        else $error("reflected ray with illegal bounce count");

endmodule

`default_nettype wire

// File: rtl/ray_fifo.sv
// Circular ray buffer for every stage; full rises early to leave room for one ray in flight
`timescale 1ns/10ps
`default_nettype none

module ray_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head word is visible without a read cycle
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    // Fewer than two free slots
    assign full  = (count >= CNT_W'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH, any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer ignored full for more than the one slack slot
    assert property (@(posedge clk) disable iff (!resetn)
        (push && !pop) |-> (count != CNT_W'(DEPTH)))
        else $error("ray_fifo overflow");

    // Consumer popped with nothing stored
    assert property (@(posedge clk) disable iff (!resetn) pop |-> !empty)
        else $error("ray_fifo underflow");

endmodule

`default_nettype wire

// File: rtl/ray_core_pkg.sv
// Ray field widths and colour limits, imported by the ray core blocks and the testbench
`default_nettype none

package ray_core_pkg;

    // --------------------------------------------------
    // Ray fields
    // --------------------------------------------------

    // Pixel coordinate, one axis
    localparam int COORD_W   = 8;

    // Colour channel and accumulator
    localparam int COLOR_W   = 8;

    // Signed vertical direction, negative points at the floor
    localparam int DIR_W     = 8;

    // Bounce count
    localparam int BOUNCE_W  = 2;

    // Pixel index is row joined to column
    localparam int PIX_W     = 2 * COORD_W;

    // --------------------------------------------------
    // Derived values
    // --------------------------------------------------

    // Accumulated colour saturates here
    localparam int COLOR_MAX = 255;

    // Ray word as stored in the stage FIFOs: px, py, dir_y, bounce, acc
    localparam int RAY_W     = 2 * COORD_W + DIR_W + BOUNCE_W + COLOR_W;

endpackage

`default_nettype wire
